/* flist.f */
+incdir+hw
hw/c64_ldr_pkg.sv
hw/prg_injector.sv
hw/tap_streamer.sv
hw/io_slot_arbiter.sv
hw/c64_loader_top.sv
tests/c64_loader_props.sv
tests/c64_loader_tb.sv

/* tests/c64_loader_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "c64_ldr_macros.svh"

module c64_loader_tb;

	import c64_ldr_pkg::*;

	localparam int DL_TIMEOUT    = 200;
	localparam int START_TIMEOUT = 3000;
	localparam int TAPE_TIMEOUT  = 6000;

	logic      clk_sys;
	logic      reset_n;
	logic      dl_active_i;
	dl_index_t dl_index_i;
	logic      dl_wr_i;
	mem_addr_t dl_addr_i;
	mem_data_t dl_data_i;
	logic      io_cycle_i;
	mem_data_t mem_rdata_i;
	logic      tape_full_i;
	logic      tape_play_btn_i;
	logic      tape_unload_i;
	logic      dl_wait_o;
	logic      mem_ce_o;
	logic      mem_we_o;
	mem_addr_t mem_addr_o;
	mem_data_t mem_wdata_o;
	mem_data_t tape_data_o;
	logic      tape_wr_o;
	logic      tape_playing_o;
	logic      start_run_o;

	// Sparse external memory
	mem_data_t   mem_model [mem_addr_t];
	logic [2:0]  io_cnt;

	// Download contents kept for the reference model
	logic [15:0] prg_load;
	int          prg_len;
	mem_data_t   prg_img [$];
	int          tap_len;
	mem_data_t   tap_img [$];
	int          tape_idx;
	int          start_cnt;

	c64_loader_top c64_loader_top_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.io_cycle_i      (io_cycle_i),
		.mem_rdata_i     (mem_rdata_i),
		.tape_full_i     (tape_full_i),
		.tape_play_btn_i (tape_play_btn_i),
		.tape_unload_i   (tape_unload_i),
		.dl_wait_o       (dl_wait_o),
		.mem_ce_o        (mem_ce_o),
		.mem_we_o        (mem_we_o),
		.mem_addr_o      (mem_addr_o),
		.mem_wdata_o     (mem_wdata_o),
		.tape_data_o     (tape_data_o),
		.tape_wr_o       (tape_wr_o),
		.tape_playing_o  (tape_playing_o),
		.start_run_o     (start_run_o)
	);

	always #5 clk_sys = ~clk_sys;

	// ========================================
	// Reference model and compare tasks
	// ========================================
	function automatic mem_data_t mem_peek(mem_addr_t a);
		if (mem_model.exists(a))
			return mem_model[a];
		return 8'h00;
	endfunction

	// Expected memory byte after the downloads sent so far
	function automatic mem_data_t ref_byte(mem_addr_t a);
		logic [15:0] end_a;
		int          off;
		end_a = prg_load + 16'(prg_len);
		if (a >= `LDR_TAP_BASE) begin
			off = int'(a - `LDR_TAP_BASE);
			return (off < tap_len) ? tap_img[off] : 8'h00;
		end
		// Zero page as a BASIC LOAD leaves it
		case (a)
			25'h2B: return 8'h01;
			25'h2C: return 8'h08;
			25'hAC, 25'hAD: return 8'h00;
			25'h2D, 25'h2F, 25'h31, 25'hAE: return end_a[7:0];
			25'h2E, 25'h30, 25'h32, 25'hAF: return end_a[15:8];
			default: ;
		endcase
		off = int'(a) - int'(prg_load);
		if (off >= 0 && off < prg_len)
			return prg_img[off];
		return 8'h00;
	endfunction

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(mem_data_t got, mem_data_t exp, string what);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %0t: %s is %02h, expected %02h",
				$time, what, got, exp));
	endtask

	task automatic check_addr(mem_addr_t got, mem_addr_t exp, string what);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %0t: %s is %07h, expected %07h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp)
			report_failure($sformatf("[ERROR] %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// ========================================
	// Memory model, slot pattern, monitors
	// ========================================
	always @(posedge clk_sys) begin
		#1;
		if (mem_ce_o === 1'b1 && mem_we_o === 1'b1)
			mem_model[mem_addr_o] = mem_wdata_o;
		if (^mem_addr_o === 1'bx)
			mem_rdata_i = 8'h00;
		else
			mem_rdata_i = mem_peek(mem_addr_o);
	end

	// 4 cycles high then 4 low
	always @(posedge clk_sys) begin
		#1;
		io_cnt     = io_cnt + 3'd1;
		io_cycle_i = !io_cnt[2];
	end

	always @(negedge clk_sys) begin
		if (reset_n && start_run_o === 1'b1)
			start_cnt++;
	end

	// Tape FIFO gets the bytes in file order then the guard byte
	always @(negedge clk_sys) begin
		if (reset_n && tape_wr_o === 1'b1) begin
			if (tape_idx > tap_len)
				report_failure("The tape FIFO received a byte past the guard byte");
			else begin
				check_byte(tape_data_o, ref_byte(`LDR_TAP_BASE + mem_addr_t'(tape_idx)),
					$sformatf("tape byte %0d", tape_idx));
				tape_idx++;
			end
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic idle(int n);
		repeat (n) step();
	endtask

	task automatic wait_dl_ready();
		int cyc;
		cyc = 0;
		while (dl_wait_o !== 1'b0) begin
			if (cyc == DL_TIMEOUT)
				report_failure("Timeout: dl_wait_o stayed high, a download write was never granted");
			else begin
				step();
				cyc++;
			end
		end
	endtask

	task automatic wait_start(int target);
		int cyc;
		cyc = 0;
		while (start_cnt < target) begin
			if (cyc == START_TIMEOUT)
				report_failure("Timeout: start_run_o did not pulse after the PRG download");
			else begin
				step();
				cyc++;
			end
		end
	endtask

	task automatic wait_tape_bytes(int n);
		int cyc;
		cyc = 0;
		while (tape_idx < n) begin
			if (cyc == TAPE_TIMEOUT)
				report_failure("Timeout: the tape FIFO did not receive the expected bytes");
			else begin
				step();
				cyc++;
			end
		end
	endtask

	// Strobe only while the DUT is not holding the source
	task automatic send_byte(mem_addr_t offset, mem_data_t data);
		wait_dl_ready();
		dl_addr_i = offset;
		dl_data_i = data;
		dl_wr_i   = 1'b1;
		step();
		dl_wr_i   = 1'b0;
	endtask

	task automatic send_prg(logic [15:0] load, int len);
		prg_load = load;
		prg_len  = len;
		prg_img.delete();
		for (int i = 0; i < len; i++)
			prg_img.push_back(mem_data_t'($urandom));
		dl_index_i  = `LDR_IDX_PRG;
		dl_active_i = 1'b1;
		step();
		send_byte(25'd0, load[7:0]);
		send_byte(25'd1, load[15:8]);
		for (int i = 0; i < len; i++)
			send_byte(mem_addr_t'(i + 2), prg_img[i]);
		wait_dl_ready();
		dl_active_i = 1'b0;
		step();
	endtask

	// Offset stays on the last byte until the download ends
	task automatic send_tap(int n);
		tap_len = n;
		tap_img.delete();
		for (int i = 0; i < n; i++)
			tap_img.push_back(mem_data_t'($urandom));
		tape_idx    = 0;
		dl_index_i  = `LDR_IDX_TAP;
		dl_active_i = 1'b1;
		step();
		for (int i = 0; i < n; i++)
			send_byte(mem_addr_t'(i), tap_img[i]);
		wait_dl_ready();
		dl_active_i = 1'b0;
		step();
	endtask

	task automatic press_play();
		tape_play_btn_i = 1'b1;
		step();
		tape_play_btn_i = 1'b0;
		step();
	endtask

	task automatic check_prg_memory();
		mem_addr_t a;
		check_addr(mem_addr_t'({mem_peek(25'h2E), mem_peek(25'h2D)}),
			mem_addr_t'(int'(prg_load) + prg_len), "program end from VAR pointer");
		for (int i = 0; i < 'h100; i++) begin
			a = mem_addr_t'(i);
			check_byte(mem_peek(a), ref_byte(a), $sformatf("zero page byte %02h", i));
		end
		for (int i = 0; i < prg_len; i++) begin
			a = mem_addr_t'(prg_load) + mem_addr_t'(i);
			check_byte(mem_peek(a), ref_byte(a), $sformatf("program byte at %04h", a));
		end
	endtask

	task automatic check_tap_memory();
		mem_addr_t a;
		for (int i = 0; i <= tap_len; i++) begin
			a = `LDR_TAP_BASE + mem_addr_t'(i);
			check_byte(mem_peek(a), ref_byte(a), $sformatf("tape image byte %0d", i));
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		int n_tap;
		int m_tap;
		int held;
		int starts;
		void'($urandom(37));
		clk_sys         = 1'b0;
		reset_n         = 1'b0;
		dl_active_i     = 1'b0;
		dl_index_i      = '0;
		dl_wr_i         = 1'b0;
		dl_addr_i       = '0;
		dl_data_i       = '0;
		io_cnt          = 3'd0;
		io_cycle_i      = 1'b1;
		mem_rdata_i     = '0;
		tape_full_i     = 1'b0;
		tape_play_btn_i = 1'b0;
		tape_unload_i   = 1'b0;
		prg_load        = '0;
		prg_len         = 0;
		tap_len         = 0;
		tape_idx        = 0;
		start_cnt       = 0;

		repeat (5) @(posedge clk_sys);
		#1;
		reset_n = 1'b1;
		step();
		check_flag(dl_wait_o, 1'b0, "dl_wait_o after reset");
		check_flag(mem_ce_o, 1'b0, "mem_ce_o after reset");
		check_flag(mem_we_o, 1'b0, "mem_we_o after reset");
		check_flag(tape_wr_o, 1'b0, "tape_wr_o after reset");
		check_flag(start_run_o, 1'b0, "start_run_o after reset");

		// Program load, pointers and one start pulse
		starts = start_cnt;
		send_prg(16'h0400 + 16'($urandom % 32'h8000), 20 + int'($urandom % 21));
		wait_start(starts + 1);
		idle(40);
		check_count(start_cnt, starts + 1, "start pulses after PRG");
		check_prg_memory();

		// Tape playback with a pause in the middle
		n_tap = 16 + int'($urandom % 16);
		send_tap(n_tap);
		check_flag(tape_playing_o, 1'b1, "tape_playing_o after TAP download");
		wait_tape_bytes(n_tap / 3);
		press_play();
		check_flag(tape_playing_o, 1'b0, "tape_playing_o after first press");
		// A read already in flight may still land
		idle(32);
		held = tape_idx;
		idle(64);
		check_count(tape_idx, held, "tape bytes while paused");
		press_play();
		check_flag(tape_playing_o, 1'b1, "tape_playing_o after second press");
		wait_tape_bytes(n_tap + 1);
		idle(64);
		check_tap_memory();
		check_count(start_cnt, starts + 1, "start pulses after TAP");

		// FIFO held full during playback while a program downloads
		m_tap = n_tap + 8 + int'($urandom % 8);
		send_tap(m_tap);
		wait_tape_bytes(4);
		tape_full_i = 1'b1;
		idle(32);
		held   = tape_idx;
		starts = start_cnt;
		send_prg(16'h0400 + 16'($urandom % 32'h8000), 20 + int'($urandom % 21));
		wait_start(starts + 1);
		idle(64);
		check_count(tape_idx, held, "tape bytes while FIFO full");
		check_prg_memory();
		tape_full_i = 1'b0;
		wait_tape_bytes(m_tap + 1);
		idle(64);
		check_tap_memory();
		check_count(start_cnt, starts + 1, "start pulses after second PRG");

		if (c64_loader_top_i.u_io_slot_arbiter.u_arb_props.fail_cnt == 0) begin
			$display("No errors");
			$finish;
		end else begin
			report_failure("Assertions on the memory strobes failed during the run");
		end
	end

endmodule

`default_nettype wire

/* tests/c64_loader_props.sv */
`timescale 1ns/1ps
`default_nettype none

module c64_loader_props (
	input wire clk_sys,
	input wire reset_n,
	input wire mem_ce_i,
	input wire mem_we_i,
	input wire prg_wr_gnt_i,
	input wire tap_wr_gnt_i,
	input wire tap_rd_gnt_i
);

	int fail_cnt = 0;

	// ========================================
	// Memory strobes
	// ========================================
	// A write is always inside an enabled access
	we_needs_ce: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_i |-> mem_ce_i)
		else begin
			$error("mem_we_o high without mem_ce_o");
			fail_cnt++;
		end

	// One owner per slot
	one_grant: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$onehot0({prg_wr_gnt_i, tap_wr_gnt_i, tap_rd_gnt_i}))
		else begin
			$error("more than one grant in the same cycle");
			fail_cnt++;
		end

	ce_low_in_reset: assert property (@(posedge clk_sys) !reset_n |=> !mem_ce_i)
		else begin
			$error("mem_ce_o high during reset");
			fail_cnt++;
		end

endmodule

bind io_slot_arbiter c64_loader_props u_arb_props (
	.clk_sys      (clk_sys),
	.reset_n      (reset_n),
	.mem_ce_i     (mem_ce_o),
	.mem_we_i     (mem_we_o),
	.prg_wr_gnt_i (prg_wr_gnt_o),
	.tap_wr_gnt_i (tap_wr_gnt_o),
	.tap_rd_gnt_i (tap_rd_gnt_o)
);

`default_nettype wire

/* hw/c64_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module c64_loader_top (
	input  wire                           clk_sys,
	input  wire                           reset_n,
	input  wire                           dl_active_i,
	input  wire c64_ldr_pkg::dl_index_t   dl_index_i,
	input  wire                           dl_wr_i,
	input  wire c64_ldr_pkg::mem_addr_t   dl_addr_i,
	input  wire c64_ldr_pkg::mem_data_t   dl_data_i,
	input  wire                           io_cycle_i,
	input  wire c64_ldr_pkg::mem_data_t   mem_rdata_i,
	input  wire                           tape_full_i,
	input  wire                           tape_play_btn_i,
	input  wire                           tape_unload_i,
	output wire                           dl_wait_o,
	output wire                           mem_ce_o,
	output wire                           mem_we_o,
	output wire c64_ldr_pkg::mem_addr_t   mem_addr_o,
	output wire c64_ldr_pkg::mem_data_t   mem_wdata_o,
	output wire c64_ldr_pkg::mem_data_t   tape_data_o,
	output wire                           tape_wr_o,
	output wire                           tape_playing_o,
	output wire                           start_run_o
);

	import c64_ldr_pkg::*;

	logic      prg_wr_req;
	mem_addr_t prg_wr_addr;
	mem_data_t prg_wr_data;
	logic      prg_wr_gnt;
	logic      tap_wr_req;
	mem_addr_t tap_wr_addr;
	mem_data_t tap_wr_data;
	logic      tap_wr_gnt;
	logic      tap_rd_req;
	mem_addr_t tap_rd_addr;
	logic      tap_rd_gnt;
	logic      rd_valid;
	mem_data_t rd_data;

	// Hold the download source while either write is still queued
	assign dl_wait_o = prg_wr_req || tap_wr_req;

	// ========================================
	// Requesters
	// ========================================
	prg_injector u_prg_injector (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.wr_gnt_i    (prg_wr_gnt),
		.wr_req_o    (prg_wr_req),
		.wr_addr_o   (prg_wr_addr),
		.wr_data_o   (prg_wr_data),
		.start_run_o (start_run_o)
	);

	tap_streamer u_tap_streamer (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.wr_gnt_i        (tap_wr_gnt),
		.rd_gnt_i        (tap_rd_gnt),
		.rd_valid_i      (rd_valid),
		.rd_data_i       (rd_data),
		.tape_full_i     (tape_full_i),
		.tape_play_btn_i (tape_play_btn_i),
		.tape_unload_i   (tape_unload_i),
		.wr_req_o        (tap_wr_req),
		.wr_addr_o       (tap_wr_addr),
		.wr_data_o       (tap_wr_data),
		.rd_req_o        (tap_rd_req),
		.rd_addr_o       (tap_rd_addr),
		.tape_data_o     (tape_data_o),
		.tape_wr_o       (tape_wr_o),
		.tape_playing_o  (tape_playing_o)
	);

	// ========================================
	// Shared memory slot
	// ========================================
	io_slot_arbiter u_io_slot_arbiter (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.io_cycle_i    (io_cycle_i),
		.prg_wr_req_i  (prg_wr_req),
		.prg_wr_addr_i (prg_wr_addr),
		.prg_wr_data_i (prg_wr_data),
		.tap_wr_req_i  (tap_wr_req),
		.tap_wr_addr_i (tap_wr_addr),
		.tap_wr_data_i (tap_wr_data),
		.tap_rd_req_i  (tap_rd_req),
		.tap_rd_addr_i (tap_rd_addr),
		.mem_rdata_i   (mem_rdata_i),
		.prg_wr_gnt_o  (prg_wr_gnt),
		.tap_wr_gnt_o  (tap_wr_gnt),
		.tap_rd_gnt_o  (tap_rd_gnt),
		.rd_valid_o    (rd_valid),
		.rd_data_o     (rd_data),
		.mem_ce_o      (mem_ce_o),
		.mem_we_o      (mem_we_o),
		.mem_addr_o    (mem_addr_o),
		.mem_wdata_o   (mem_wdata_o)
	);

endmodule

`default_nettype wire

/* hw/io_slot_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module io_slot_arbiter (
	input  wire                           clk_sys,
	input  wire                           reset_n,
	input  wire                           io_cycle_i,
	input  wire                           prg_wr_req_i,
	input  wire c64_ldr_pkg::mem_addr_t   prg_wr_addr_i,
	input  wire c64_ldr_pkg::mem_data_t   prg_wr_data_i,
	input  wire                           tap_wr_req_i,
	input  wire c64_ldr_pkg::mem_addr_t   tap_wr_addr_i,
	input  wire c64_ldr_pkg::mem_data_t   tap_wr_data_i,
	input  wire                           tap_rd_req_i,
	input  wire c64_ldr_pkg::mem_addr_t   tap_rd_addr_i,
	input  wire c64_ldr_pkg::mem_data_t   mem_rdata_i,
	output logic                          prg_wr_gnt_o,
	output logic                          tap_wr_gnt_o,
	output logic                          tap_rd_gnt_o,
	output logic                          rd_valid_o,
	output c64_ldr_pkg::mem_data_t        rd_data_o,
	output logic                          mem_ce_o,
	output logic                          mem_we_o,
	output c64_ldr_pkg::mem_addr_t        mem_addr_o,
	output c64_ldr_pkg::mem_data_t        mem_wdata_o
);

	import c64_ldr_pkg::*;

	logic    io_cyc_d;
	logic    slot_open;
	logic    slot_close;
	io_src_t owner;
	io_src_t pick;

	// Slot opens on the falling edge of io_cycle and closes after two highs
	assign slot_open  = io_cyc_d && !io_cycle_i;
	assign slot_close = io_cyc_d && io_cycle_i;

	// Fixed priority with downloads first
	always_comb begin
		if (prg_wr_req_i)
			pick = SRC_PRG_WR;
		else if (tap_wr_req_i)
			pick = SRC_TAP_WR;
		else if (tap_rd_req_i)
			pick = SRC_TAP_RD;
		else
			pick = SRC_NONE;
	end

	// ========================================
	// Slot control
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cyc_d     <= 1'b0;
			owner        <= SRC_NONE;
			mem_ce_o     <= 1'b0;
			mem_we_o     <= 1'b0;
			prg_wr_gnt_o <= 1'b0;
			tap_wr_gnt_o <= 1'b0;
			tap_rd_gnt_o <= 1'b0;
			rd_valid_o   <= 1'b0;
		end else begin
			io_cyc_d     <= io_cycle_i;
			prg_wr_gnt_o <= 1'b0;
			tap_wr_gnt_o <= 1'b0;
			tap_rd_gnt_o <= 1'b0;
			rd_valid_o   <= 1'b0;

			if (slot_open) begin
				owner        <= pick;
				mem_ce_o     <= (pick != SRC_NONE);
				mem_we_o     <= (pick == SRC_PRG_WR) || (pick == SRC_TAP_WR);
				prg_wr_gnt_o <= (pick == SRC_PRG_WR);
				tap_wr_gnt_o <= (pick == SRC_TAP_WR);
				tap_rd_gnt_o <= (pick == SRC_TAP_RD);
			end

			if (slot_close) begin
				owner      <= SRC_NONE;
				mem_ce_o   <= 1'b0;
				mem_we_o   <= 1'b0;
				rd_valid_o <= (owner == SRC_TAP_RD);
			end
		end
	end

	// ========================================
	// Address, write data and read return
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (slot_open) begin
			case (pick)
				SRC_PRG_WR: begin
					mem_addr_o  <= prg_wr_addr_i;
					mem_wdata_o <= prg_wr_data_i;
				end
				SRC_TAP_WR: begin
					mem_addr_o  <= tap_wr_addr_i;
					mem_wdata_o <= tap_wr_data_i;
				end
				SRC_TAP_RD: mem_addr_o <= tap_rd_addr_i;
				default: begin
				end
			endcase
		end
		// Read data is stable by the last cycle of the slot
		if (slot_close && owner == SRC_TAP_RD)
			rd_data_o <= mem_rdata_i;
	end

endmodule

`default_nettype wire

/* hw/tap_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "c64_ldr_macros.svh"

module tap_streamer (
	input  wire                           clk_sys,
	input  wire                           reset_n,
	input  wire                           dl_active_i,
	input  wire c64_ldr_pkg::dl_index_t   dl_index_i,
	input  wire                           dl_wr_i,
	input  wire c64_ldr_pkg::mem_addr_t   dl_addr_i,
	input  wire c64_ldr_pkg::mem_data_t   dl_data_i,
	input  wire                           wr_gnt_i,
	input  wire                           rd_gnt_i,
	input  wire                           rd_valid_i,
	input  wire c64_ldr_pkg::mem_data_t   rd_data_i,
	input  wire                           tape_full_i,
	input  wire                           tape_play_btn_i,
	input  wire                           tape_unload_i,
	output logic                          wr_req_o,
	output c64_ldr_pkg::mem_addr_t        wr_addr_o,
	output c64_ldr_pkg::mem_data_t        wr_data_o,
	output logic                          rd_req_o,
	output c64_ldr_pkg::mem_addr_t        rd_addr_o,
	output c64_ldr_pkg::mem_data_t        tape_data_o,
	output logic                          tape_wr_o,
	output logic                          tape_playing_o
);

	import c64_ldr_pkg::*;

	logic      is_tap;
	logic      tap_dl;
	logic      tap_reset;
	logic      tap_loaded;
	logic      play_btn_d;
	logic      rd_pend;
	mem_addr_t play_addr;
	mem_addr_t last_addr;

	assign is_tap     = (dl_index_i == `LDR_IDX_TAP);
	assign tap_dl     = dl_active_i && is_tap;
	assign tap_reset  = tap_dl || tape_unload_i;
	assign tap_loaded = (play_addr < last_addr);
	assign rd_addr_o  = `LDR_TAP_BASE + play_addr;

	// ========================================
	// Download side
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_req_o <= 1'b0;
		end else begin
			if (wr_gnt_i)
				wr_req_o <= 1'b0;
			if (dl_wr_i && is_tap)
				wr_req_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_wr_i && is_tap) begin
			wr_addr_o <= `LDR_TAP_BASE + dl_addr_i;
			wr_data_o <= dl_data_i;
		end
		if (rd_valid_i)
			tape_data_o <= rd_data_i;
	end

	// ========================================
	// Playback side
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			rd_req_o       <= 1'b0;
			rd_pend        <= 1'b0;
			play_addr      <= '0;
			last_addr      <= '0;
			play_btn_d     <= 1'b0;
			tape_wr_o      <= 1'b0;
			tape_playing_o <= 1'b0;
		end else begin
			play_btn_d <= tape_play_btn_i;
			tape_wr_o  <= 1'b0;

			if (tap_reset) begin
				// One spare byte past the end for the FIFO early check
				last_addr      <= tap_dl ? dl_addr_i + `LDR_TAP_GUARD : '0;
				play_addr      <= '0;
				rd_req_o       <= 1'b0;
				rd_pend        <= 1'b0;
				tape_playing_o <= tap_dl;
			end else begin
				if (tape_play_btn_i && !play_btn_d)
					tape_playing_o <= !tape_playing_o;

				if (tape_playing_o && tap_loaded && !tape_full_i && !rd_req_o && !rd_pend)
					rd_req_o <= 1'b1;

				if (rd_gnt_i && rd_req_o) begin
					rd_req_o  <= 1'b0;
					rd_pend   <= 1'b1;
					play_addr <= play_addr + 1'b1;
				end

				// Granted read completes even if the FIFO filled meanwhile
				if (rd_valid_i && rd_pend) begin
					rd_pend   <= 1'b0;
					tape_wr_o <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/prg_injector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "c64_ldr_macros.svh"

module prg_injector (
	input  wire                           clk_sys,
	input  wire                           reset_n,
	input  wire                           dl_active_i,
	input  wire c64_ldr_pkg::dl_index_t   dl_index_i,
	input  wire                           dl_wr_i,
	input  wire c64_ldr_pkg::mem_addr_t   dl_addr_i,
	input  wire c64_ldr_pkg::mem_data_t   dl_data_i,
	input  wire                           wr_gnt_i,
	output logic                          wr_req_o,
	output c64_ldr_pkg::mem_addr_t        wr_addr_o,
	output c64_ldr_pkg::mem_data_t        wr_data_o,
	output logic                          start_run_o
);

	import c64_ldr_pkg::*;

	logic        is_prg;
	logic        prg_dl;
	logic        meminit;
	logic [15:0] end_addr;
	logic        scan_hit;
	mem_data_t   scan_data;

	assign is_prg = (dl_index_i == `LDR_IDX_PRG);

	// ========================================
	// BASIC pointer table
	// ========================================
	// Values a BASIC LOAD leaves in zero page
	always_comb begin
		scan_hit  = 1'b1;
		scan_data = '0;
		case (wr_addr_o[7:0])
			// TXT start is the same as after reset
			8'h2B: scan_data = 8'h01;
			8'h2C: scan_data = 8'h08;
			// SAVE start is untouched by LOAD
			8'hAC, 8'hAD: scan_data = 8'h00;
			// VAR, ARY, STR and LOAD end all point past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: scan_data = end_addr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: scan_data = end_addr[15:8];
			default: scan_hit = 1'b0;
		endcase
	end

	// ========================================
	// Header parse, data writes, meminit scan
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_req_o    <= 1'b0;
			prg_dl      <= 1'b0;
			meminit     <= 1'b0;
			start_run_o <= 1'b0;
		end else begin
			start_run_o <= 1'b0;

			if (dl_active_i && is_prg)
				prg_dl <= 1'b1;

			// Slot taken so move on to the next byte
			if (wr_gnt_i) begin
				wr_req_o  <= 1'b0;
				wr_addr_o <= wr_addr_o + 1'b1;
			end

			if (dl_wr_i && is_prg) begin
				if (dl_addr_i == '0) begin
					// Load address low byte
					wr_addr_o     <= mem_addr_t'(dl_data_i);
					end_addr[7:0] <= dl_data_i;
				end else if (dl_addr_i == 25'd1) begin
					// Load address high byte
					wr_addr_o[15:8] <= dl_data_i;
					end_addr[15:8]  <= dl_data_i;
				end else begin
					wr_req_o  <= 1'b1;
					wr_data_o <= dl_data_i;
					end_addr  <= end_addr + 16'd1;
				end
			end

			// Download over and last byte stored
			if (prg_dl && !dl_active_i && !meminit && !wr_req_o) begin
				prg_dl    <= 1'b0;
				meminit   <= 1'b1;
				wr_addr_o <= '0;
			end

			if (meminit && !wr_req_o) begin
				if (wr_addr_o == `LDR_MEMINIT_END) begin
					meminit     <= 1'b0;
					start_run_o <= 1'b1;
				end else if (scan_hit) begin
					wr_req_o  <= 1'b1;
					wr_data_o <= scan_data;
				end else begin
					wr_addr_o <= wr_addr_o + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/c64_ldr_pkg.sv */
`default_nettype none

`include "c64_ldr_macros.svh"

package c64_ldr_pkg;

	// ========================================
	// Memory and download types
	// ========================================
	// Byte address into the shared external memory
	typedef logic [`LDR_ADDR_W-1:0] mem_addr_t;

	// One memory byte
	typedef logic [`LDR_DATA_W-1:0] mem_data_t;

	// File kind on the download port
	typedef logic [7:0] dl_index_t;

	// ========================================
	// Slot ownership
	// ========================================
	// Which requester holds the current I/O slot
	typedef enum logic [1:0] {
		SRC_NONE   = 2'd0,
		SRC_PRG_WR = 2'd1,
		SRC_TAP_WR = 2'd2,
		SRC_TAP_RD = 2'd3
	} io_src_t;

endpackage

`default_nettype wire

/* hw/c64_ldr_macros.svh */
`ifndef C64_LDR_MACROS_SVH
`define C64_LDR_MACROS_SVH

// ========================================
// Bus widths
// ========================================
`define LDR_ADDR_W      25
`define LDR_DATA_W      8

// ========================================
// Memory map
// ========================================
// Tape image region in external memory
`define LDR_TAP_BASE    25'h200000
// First address past the zero page pointer scan
`define LDR_MEMINIT_END 25'h100
// Extra reads past the last tape offset
`define LDR_TAP_GUARD   25'd2

// ========================================
// Download file indexes
// ========================================
`define LDR_IDX_PRG     8'd4
`define LDR_IDX_TAP     8'd6

`endif
